//--- decode_pkg.sv
// ==================================================
// Shared definitions for the decode stage
// Widths, instruction field positions, opcode,
// access size and prefix state encodings
// ==================================================

package decode_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int instr_w = 40;
	localparam int value_w = 64;
	localparam int reg_w   = 5;
	localparam int opc_w   = 7;
	localparam int imm_w   = 18;
	localparam int jmp_w   = 28;
	localparam int pfx_w   = 33;

	// Prefix payload joined with the low immediate bits
	localparam int wide_w  = pfx_w + imm_w;

	typedef logic [instr_w-1:0] instr_t;
	typedef logic [value_w-1:0] value_t;
	typedef logic [reg_w-1:0]   regno_t;

	// ==================================================
	// Field positions
	// ==================================================
	localparam int opc_lsb  = 0;
	localparam int opc_msb  = opc_lsb + opc_w - 1;

	localparam int rt_lsb   = 7;
	localparam int rt_msb   = rt_lsb + reg_w - 1;

	localparam int ra_lsb   = 12;
	localparam int ra_msb   = ra_lsb + reg_w - 1;

	localparam int rb_lsb   = 17;
	localparam int rb_msb   = rb_lsb + reg_w - 1;

	// Short immediate sits in the top bits of the word
	localparam int imm_lsb  = 22;
	localparam int imm_msb  = imm_lsb + imm_w - 1;

	// Jump field overlaps ra, rb and the immediate
	localparam int jfld_lsb = 12;
	localparam int jfld_msb = jfld_lsb + jmp_w - 1;

	// Everything above the opcode in a prefix word
	localparam int pfx_lsb  = 7;
	localparam int pfx_msb  = pfx_lsb + pfx_w - 1;

	// ==================================================
	// Encodings
	// ==================================================
	// Unlisted encodings decode like NOP
	typedef enum logic [opc_w-1:0] {
		ADD  = 7'h02,
		ADDI = 7'h04,
		ANDI = 7'h08,
		ORI  = 7'h09,
		NOP  = 7'h0c,
		JMP  = 7'h20,
		JEQ  = 7'h26,
		LDB  = 7'h40,
		LDBU = 7'h41,
		LDW  = 7'h42,
		LDWU = 7'h43,
		LDO  = 7'h46,
		STB  = 7'h50,
		STW  = 7'h51,
		STO  = 7'h54,
		EXI  = 7'h7c
	} opcode_e;

	typedef enum logic [1:0] {
		byt  = 2'd0,
		wyde = 2'd1,
		octa = 2'd2
	} memsz_e;

	typedef enum logic {
		idle = 1'b0,
		held = 1'b1
	} pfx_state_e;

endpackage

//--- decode_if.sv
// ==================================================
// Decoded instruction bundle
// Shared by the decoders, prefix FSM and stage register
// ==================================================

`timescale 1ns/10ps

interface decode_if
	import decode_pkg::*;
();
	regno_t ra;
	regno_t rb;
	regno_t rc;
	regno_t rt;
	logic   rfwr;
	value_t imm;
	value_t jmptgt;
	logic   ld;
	logic   ldz;
	logic   st;
	memsz_e memsz;
	logic   jmp;
	logic   jxx;
	logic   is_prefix;

	modport fields (output ra, rb, rc, rt, rfwr, ld, ldz, st, memsz, jmp, jxx, is_prefix);
	modport immgen (output imm, jmptgt);
	modport fsm    (input is_prefix);
	modport stage  (input ra, rb, rc, rt, rfwr, imm, jmptgt, ld, ldz, st, memsz, jmp, jxx,
		is_prefix);
endinterface

//--- prefix_fsm.sv
// ==================================================
// Extension prefix tracker
// Holds an EXI payload until the next word uses it
// ==================================================

`timescale 1ns/10ps

module prefix_fsm
	import decode_pkg::*;
(
	input  logic             clk,
	input  logic             arst_n,
	input  instr_t           inst,
	input  logic             accept,
	decode_if.fsm            dec,
	output logic             pfx_valid,
	output logic [pfx_w-1:0] pfx_bits
);

	pfx_state_e state;
	pfx_state_e state_nx;

	always_comb
	begin
		state_nx = state;
		case (state)
			idle:
				if (accept && dec.is_prefix)
					state_nx = held;
			// Any accepted non-prefix word consumes the prefix
			held:
				if (accept && !dec.is_prefix)
					state_nx = idle;
			default:
				state_nx = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= idle;
		else
			state <= state_nx;
	end

	// A second prefix in a row overwrites the first
	always_ff @(posedge clk)
	begin
		if (accept && dec.is_prefix)
			pfx_bits <= inst[pfx_msb:pfx_lsb];
	end

	assign pfx_valid = (state == held);

endmodule

//--- field_decode.sv
// ==================================================
// Register specifier and class decode
// Write enable, memory class and branch class
// ==================================================

`timescale 1ns/10ps

module field_decode
	import decode_pkg::*;
(
	input  instr_t    inst,
	decode_if.fields  dec
);

	opcode_e opc;
	regno_t  fld_rt;

	assign opc    = opcode_e'(inst[opc_msb:opc_lsb]);
	assign fld_rt = inst[rt_msb:rt_lsb];

	// ==================================================
	// Register specifiers
	// ==================================================
	always_comb
	begin
		dec.ra = inst[ra_msb:ra_lsb];
		dec.rb = inst[rb_msb:rb_lsb];

		// Stores carry their data register in the rt slot
		case (opc)
			STB, STW, STO:
				dec.rc = fld_rt;
			default:
				dec.rc = '0;
		endcase

		case (opc)
			ADD, ADDI, ANDI, ORI,
			LDB, LDBU, LDW, LDWU, LDO:
				dec.rt = fld_rt;
			// Stores, branches, NOP and prefixes target nothing
			default:
				dec.rt = '0;
		endcase
	end

	// Register file write
	always_comb
	begin
		case (opc)
			ADD, ADDI, ANDI, ORI:
				dec.rfwr = 1'b1;
			LDB, LDBU, LDW, LDWU, LDO:
				dec.rfwr = 1'b1;
			default:
				dec.rfwr = 1'b0;
		endcase
	end

	// ==================================================
	// Memory class
	// ==================================================
	always_comb
	begin
		dec.ld  = 1'b0;
		dec.ldz = 1'b0;
		dec.st  = 1'b0;
		case (opc)
			LDB, LDW, LDO:
				dec.ld = 1'b1;
			LDBU, LDWU:
			begin
				dec.ld  = 1'b1;
				dec.ldz = 1'b1;
			end
			STB, STW, STO:
				dec.st = 1'b1;
			default:
				dec.ld = 1'b0;
		endcase

		case (opc)
			LDB, LDBU, STB:
				dec.memsz = byt;
			LDW, LDWU, STW:
				dec.memsz = wyde;
			default:
				dec.memsz = octa;
		endcase
	end

	// Branch class and prefix detect
	always_comb
	begin
		dec.jmp       = (opc == JMP);
		dec.jxx       = (opc == JEQ);
		dec.is_prefix = (opc == EXI);
	end

endmodule

//--- imm_gen.sv
// ==================================================
// Immediate and jump target generation
// Includes widening by a held EXI prefix
// ==================================================

`timescale 1ns/10ps

module imm_gen
	import decode_pkg::*;
(
	input  instr_t           inst,
	input  logic             pfx_valid,
	input  logic [pfx_w-1:0] pfx_bits,
	decode_if.immgen         dec
);

	opcode_e           opc;
	logic [imm_w-1:0]  imm_fld;
	logic [jmp_w-1:0]  jmp_fld;
	logic [wide_w-1:0] wide;
	logic              uses_imm;
	value_t            base_imm;

	assign opc     = opcode_e'(inst[opc_msb:opc_lsb]);
	assign imm_fld = inst[imm_msb:imm_lsb];
	assign jmp_fld = inst[jfld_msb:jfld_lsb];
	assign wide    = {pfx_bits, imm_fld};

	// ==================================================
	// Immediate
	// ==================================================
	always_comb
	begin
		uses_imm = 1'b1;
		case (opc)
			ADDI,
			LDB, LDBU, LDW, LDWU, LDO,
			STB, STW, STO:
				base_imm = {{(value_w-imm_w){imm_fld[imm_w-1]}}, imm_fld};
			// Mask style constant keeps upper bits for AND
			ANDI:
				base_imm = {{(value_w-imm_w){1'b1}}, imm_fld};
			ORI:
				base_imm = {{(value_w-imm_w){1'b0}}, imm_fld};
			default:
			begin
				base_imm = '0;
				uses_imm = 1'b0;
			end
		endcase

		// Prefix replaces the extension above the low field bits
		if (pfx_valid && uses_imm)
			dec.imm = {{(value_w-wide_w){wide[wide_w-1]}}, wide};
		else
			dec.imm = base_imm;
	end

	// Jump target, halfword aligned
	always_comb
	begin
		case (opc)
			JMP:
				dec.jmptgt = {{(value_w-jmp_w-1){jmp_fld[jmp_w-1]}}, jmp_fld, 1'b0};
			JEQ:
				dec.jmptgt = {{(value_w-imm_w-1){imm_fld[imm_w-1]}}, imm_fld, 1'b0};
			default:
				dec.jmptgt = '0;
		endcase
	end

endmodule

//--- decode_stage.sv
// ==================================================
// Decode output register
// Valid/ready handshake on both sides
// ==================================================

`timescale 1ns/10ps

module decode_stage
	import decode_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   inst_valid,
	input  logic   dec_ready,
	decode_if.stage dec,
	output logic   inst_ready,
	output logic   accept,
	output logic   dec_valid,
	output regno_t ra,
	output regno_t rb,
	output regno_t rc,
	output regno_t rt,
	output logic   rfwr,
	output value_t imm,
	output value_t jmptgt,
	output logic   ld,
	output logic   ldz,
	output logic   st,
	output memsz_e memsz,
	output logic   jmp,
	output logic   jxx
);

	logic load;

	// Room when empty or the current item leaves this cycle
	assign inst_ready = !dec_valid || dec_ready;
	assign accept     = inst_valid && inst_ready;
	assign load       = accept && !dec.is_prefix;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			dec_valid <= 1'b0;
		else if (load)
			dec_valid <= 1'b1;
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			ra     <= dec.ra;
			rb     <= dec.rb;
			rc     <= dec.rc;
			rt     <= dec.rt;
			rfwr   <= dec.rfwr;
			imm    <= dec.imm;
			jmptgt <= dec.jmptgt;
			ld     <= dec.ld;
			ldz    <= dec.ldz;
			st     <= dec.st;
			memsz  <= dec.memsz;
			jmp    <= dec.jmp;
			jxx    <= dec.jxx;
		end
	end

endmodule

//--- decoder_top.sv
// ==================================================
// Pipelined instruction decode stage, top level
// ==================================================

`timescale 1ns/10ps

module decoder_top
	import decode_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  instr_t inst,
	input  logic   inst_valid,
	output logic   inst_ready,
	output logic   dec_valid,
	input  logic   dec_ready,
	output regno_t ra,
	output regno_t rb,
	output regno_t rc,
	output regno_t rt,
	output logic   rfwr,
	output value_t imm,
	output value_t jmptgt,
	output logic   ld,
	output logic   ldz,
	output logic   st,
	output memsz_e memsz,
	output logic   jmp,
	output logic   jxx
);

	logic             accept;
	logic             pfx_valid;
	logic [pfx_w-1:0] pfx_bits;

	decode_if dec_bus ();

	field_decode field_decode_inst (
		.inst (inst),
		.dec  (dec_bus.fields)
	);

	imm_gen imm_gen_inst (
		.inst      (inst),
		.pfx_valid (pfx_valid),
		.pfx_bits  (pfx_bits),
		.dec       (dec_bus.immgen)
	);

	prefix_fsm prefix_fsm_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.inst      (inst),
		.accept    (accept),
		.dec       (dec_bus.fsm),
		.pfx_valid (pfx_valid),
		.pfx_bits  (pfx_bits)
	);

	decode_stage decode_stage_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.dec_ready  (dec_ready),
		.dec        (dec_bus.stage),
		.inst_ready (inst_ready),
		.accept     (accept),
		.dec_valid  (dec_valid),
		.ra         (ra),
		.rb         (rb),
		.rc         (rc),
		.rt         (rt),
		.rfwr       (rfwr),
		.imm        (imm),
		.jmptgt     (jmptgt),
		.ld         (ld),
		.ldz        (ldz),
		.st         (st),
		.memsz      (memsz),
		.jmp        (jmp),
		.jxx        (jxx)
	);

endmodule

//--- tb_decoder.sv
// ==================================================
// Testbench for the pipelined decode stage
// Random stimulus, reference model, queue compare
// ==================================================

`timescale 1ns/10ps

module tb_decoder
	import decode_pkg::*;
();

	// Expected or observed decoded item, in output port order
	typedef struct packed {
		regno_t ra;
		regno_t rb;
		regno_t rc;
		regno_t rt;
		logic   rfwr;
		value_t imm;
		value_t jmptgt;
		logic   ld;
		logic   ldz;
		logic   st;
		memsz_e memsz;
		logic   jmp;
		logic   jxx;
	} item_t;

	logic   clk;
	logic   arst_n;
	instr_t inst;
	logic   inst_valid;
	logic   inst_ready;
	logic   dec_valid;
	logic   dec_ready;
	regno_t ra;
	regno_t rb;
	regno_t rc;
	regno_t rt;
	logic   rfwr;
	value_t imm;
	value_t jmptgt;
	logic   ld;
	logic   ldz;
	logic   st;
	memsz_e memsz;
	logic   jmp;
	logic   jxx;

	item_t       exp_q[$];
	item_t       act;
	item_t       exp;
	item_t       held_out;
	opcode_e     opc_list[16];
	string       test_name;
	logic        will_accept;
	logic        stalled;
	logic        pfx_held;
	logic [32:0] pfx_pay;
	logic        timed_out;
	int          err_count;
	int          check_count;
	int          tests_run;
	int          tests_failed;

	decoder_top decoder_top_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst       (inst),
		.inst_valid (inst_valid),
		.inst_ready (inst_ready),
		.dec_valid  (dec_valid),
		.dec_ready  (dec_ready),
		.ra         (ra),
		.rb         (rb),
		.rc         (rc),
		.rt         (rt),
		.rfwr       (rfwr),
		.imm        (imm),
		.jmptgt     (jmptgt),
		.ld         (ld),
		.ldz        (ldz),
		.st         (st),
		.memsz      (memsz),
		.jmp        (jmp),
		.jxx        (jxx)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// ==================================================
	// Reference model
	// ==================================================
	function automatic item_t model_decode(input instr_t w, input logic held,
		input logic [32:0] pay);
		item_t       e;
		logic [6:0]  op;
		logic [17:0] f;
		logic [27:0] jf;
		logic [50:0] wide;
		logic        is_ld;
		logic        is_st;
		logic        is_alu;
		begin
			op     = w[6:0];
			f      = w[39:22];
			jf     = w[39:12];
			wide   = {pay, f};
			is_ld  = op inside {LDB, LDBU, LDW, LDWU, LDO};
			is_st  = op inside {STB, STW, STO};
			is_alu = op inside {ADD, ADDI, ANDI, ORI};
			e      = '0;
			e.ra   = w[16:12];
			e.rb   = w[21:17];
			e.rt   = (is_ld || is_alu) ? w[11:7] : 5'd0;
			e.rc   = is_st ? w[11:7] : 5'd0;
			e.rfwr = is_ld || is_alu;
			e.ld   = is_ld;
			e.ldz  = op inside {LDBU, LDWU};
			e.st   = is_st;
			e.jmp  = (op == JMP);
			e.jxx  = (op == JEQ);
			e.memsz = octa;
			if (op inside {LDB, LDBU, STB})
				e.memsz = byt;
			else if (op inside {LDW, LDWU, STW})
				e.memsz = wyde;
			if (is_ld || is_st || op == ADDI)
				e.imm = {{46{f[17]}}, f};
			else if (op == ANDI)
				e.imm = {{46{1'b1}}, f};
			else if (op == ORI)
				e.imm = {46'd0, f};
			// Held prefix supplies the upper 33 bits
			if (held && (is_ld || is_st || op inside {ADDI, ANDI, ORI}))
				e.imm = {{13{wide[50]}}, wide};
			if (op == JMP)
				e.jmptgt = {{35{jf[27]}}, jf, 1'b0};
			else if (op == JEQ)
				e.jmptgt = {{45{f[17]}}, f, 1'b0};
			return e;
		end
	endfunction

	// ==================================================
	// Output monitor and model update
	// ==================================================
	initial
	begin
		will_accept = 1'b0;
		stalled     = 1'b0;
		pfx_held    = 1'b0;
		pfx_pay     = '0;
		forever
		begin
			@(negedge clk);
			act = {ra, rb, rc, rt, rfwr, imm, jmptgt, ld, ldz, st, memsz, jmp, jxx};
			if (arst_n !== 1'b1)
			begin
				will_accept = 1'b0;
				stalled     = 1'b0;
				pfx_held    = 1'b0;
			end
			else
			begin
				// Output register holds exactly the queued items
				if (dec_valid !== (exp_q.size() != 0))
				begin
					$display("Fail %s: dec_valid expected %b actual %b", test_name,
						exp_q.size() != 0, dec_valid);
					err_count++;
				end
				if (inst_ready !== (exp_q.size() == 0 || dec_ready))
				begin
					$display("Fail %s: inst_ready expected %b actual %b", test_name,
						exp_q.size() == 0 || dec_ready, inst_ready);
					err_count++;
				end
				if (stalled && !dec_valid)
				begin
					$display("In %s dec_valid dropped while the output was stalled", test_name);
					err_count++;
				end
				else if (stalled && act !== held_out)
				begin
					$display("Fail %s: held output expected %h actual %h", test_name,
						held_out, act);
					err_count++;
				end
				if (dec_valid && dec_ready)
				begin
					if (exp_q.size() == 0)
					begin
						$display("In %s an output item appeared with nothing expected", test_name);
						err_count++;
					end
					else
					begin
						exp = exp_q.pop_front();
						check_count++;
						if (act !== exp)
						begin
							$display("Fail %s: decoded item expected %h actual %h", test_name,
								exp, act);
							err_count++;
						end
					end
				end
				stalled     = dec_valid && !dec_ready;
				held_out    = act;
				will_accept = inst_valid && inst_ready;
				if (will_accept)
				begin
					if (inst[6:0] == EXI)
					begin
						pfx_held = 1'b1;
						pfx_pay  = inst[39:7];
					end
					else
					begin
						exp_q.push_back(model_decode(inst, pfx_held, pfx_pay));
						pfx_held = 1'b0;
					end
				end
			end
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================
	function automatic instr_t next_word(input int mode, input int idx);
		instr_t      w;
		logic [31:0] r0;
		logic [31:0] r1;
		int          lo;
		int          span;
		int          pick;
		begin
			r0 = $urandom;
			r1 = $urandom;
			w  = {r1[7:0], r0};
			case (mode)
				0:
				begin
					lo   = 0;
					span = 15;
				end
				1:
				begin
					lo   = 1;
					span = 11;
				end
				3:
				begin
					lo   = 4;
					span = 10;
				end
				default:
				begin
					lo   = 0;
					span = 16;
				end
			endcase
			pick    = lo + int'($urandom % span);
			w[6:0]  = opc_list[pick[3:0]];
			// Prefix pattern is EXI, ADDI, then a plain ADDI
			if (mode == 2)
				w[6:0] = (idx % 3 == 0) ? EXI : ADDI;
			return w;
		end
	endfunction

	task automatic drive_ready(input int mode);
		begin
			if (mode == 4)
				dec_ready <= ($urandom % 2) == 0;
			else
				dec_ready <= ($urandom % 4) != 0;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		begin
			tests_run++;
			if (err_count > errs_before)
				tests_failed++;
			$display("Test %s finished with %0d errors", name, err_count - errs_before);
		end
	endtask

	task automatic idle_check(input string name);
		begin
			if (dec_valid !== 1'b0 || inst_ready !== 1'b1)
			begin
				$display("Fail %s: dec_valid,inst_ready expected 01 actual %b%b", name,
					dec_valid, inst_ready);
				err_count++;
			end
		end
	endtask

	task automatic reset_check();
		int errs;
		begin
			errs      = err_count;
			test_name = "reset_state";
			repeat (16)
			begin
				@(negedge clk);
				idle_check(test_name);
			end
			@(posedge clk);
			arst_n <= 1'b1;
			@(negedge clk);
			idle_check(test_name);
			end_test(test_name, errs);
		end
	endtask

	task automatic run_test(input string name, input int mode, input int count);
		int sent;
		int guard;
		int errs;
		begin
			errs      = err_count;
			test_name = name;
			sent      = 0;
			guard     = 0;
			while (sent < count && guard < count * 20 + 100)
			begin
				@(posedge clk);
				guard++;
				if (will_accept)
					sent++;
				drive_ready(mode);
				if (!inst_valid || will_accept)
				begin
					if (sent < count && ($urandom % 4) != 0)
					begin
						inst       <= next_word(mode, sent);
						inst_valid <= 1'b1;
					end
					else
						inst_valid <= 1'b0;
				end
			end
			// Let the output side empty the model queue
			guard = 0;
			while (exp_q.size() != 0 && guard < 400)
			begin
				@(posedge clk);
				guard++;
				drive_ready(mode);
			end
			if (sent < count || exp_q.size() != 0)
			begin
				$display("Timeout in %s with %0d words sent and %0d items still queued",
					name, sent, exp_q.size());
				err_count++;
				timed_out = 1'b1;
			end
			end_test(name, errs);
		end
	endtask

	initial
	begin
		void'($urandom(32'hcb6a));
		opc_list = '{ADD, ADDI, ANDI, ORI, LDB, LDBU, LDW, LDWU, LDO,
			STB, STW, STO, JMP, JEQ, NOP, EXI};
		err_count    = 0;
		check_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		arst_n       = 1'b0;
		inst         = '0;
		inst_valid   = 1'b0;
		dec_ready    = 1'b0;

		reset_check();
		run_test("register_fields", 0, 300);
		if (!timed_out)
			run_test("immediates", 1, 200);
		if (!timed_out)
			run_test("prefix_widening", 2, 150);
		if (!timed_out)
			run_test("mem_branch_class", 3, 200);
		if (!timed_out)
			run_test("back_pressure", 4, 600);

		$display("Tests %0d, failed %0d, items checked %0d, errors %0d",
			tests_run, tests_failed, check_count, err_count);
		if (err_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- vlog.f
decode_pkg.sv
decode_if.sv
prefix_fsm.sv
field_decode.sv
imm_gen.sv
decode_stage.sv
decoder_top.sv
tb_decoder.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_decoder
FILELIST = vlog.f
LOG      = sim.log
PASS_MSG = Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
